// ==== verilog.f ====
source/streamin_pkg.sv
source/mem_if.sv
source/streamin_ctrl.sv
source/load_fifo.sv
source/cast_in.sv
source/streamin_top.sv
bench/streamin_checker.sv
bench/streamin_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the streamer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module streamin_tb --Mdir "$BUILD" -o streamin_sim -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

"./$BUILD/streamin_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG."
exit 1

// ==== bench/streamin_tb.sv ====
// Seeded random jobs; the memory model grants after a random delay and answers one cycle later.
`timescale 1ns/1ps

module streamin_tb;
  import streamin_pkg::*;

  localparam int FIFO_DEPTH   = FIFO_DEPTH_DEF;
  localparam int NUM_JOBS     = 14;
  localparam int REQ_TIMEOUT  = 50;    // Cycles from start to the first request.
  localparam int DONE_TIMEOUT = 4000;  // Cycles for a whole job.
  localparam int IDLE_TIMEOUT = 20;

  logic              clk = 1'b0;
  logic              rst;
  logic              start;
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] stride;
  logic [LEN_W-1:0]  len;
  src_fmt_e          fmt;
  logic              busy;
  logic              done;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_gnt;
  logic              mem_rvalid;
  logic [DATA_W-1:0] mem_rdata;
  logic [DATA_W-1:0] out_data;
  logic              out_valid;
  logic              out_ready;
  logic [31:0]       key;        // Data key of the current job.
  logic              pend;       // A grant happened in the last cycle.
  logic [ADDR_W-1:0] pend_addr;
  int                gnt_wait;
  int                max_gnt_delay;
  int                ready_pct;
  int                bench_errors;
  int                chk_errors;
  int                jobs_done;
  bit                timed_out;

  initial begin
    forever #20 clk = ~clk;
  end

  streamin_top #(.FIFO_DEPTH(FIFO_DEPTH), .ADDR_W(ADDR_W)) dut0 (
    .clk_i(clk), .rst_i(rst), .start_i(start), .base_i(base), .stride_i(stride),
    .len_i(len), .fmt_i(fmt), .busy_o(busy), .done_o(done),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_gnt_i(mem_gnt),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
    .out_data_o(out_data), .out_valid_o(out_valid), .out_ready_i(out_ready)
  );

  streamin_checker #(.FIFO_DEPTH(FIFO_DEPTH), .ADDR_W(ADDR_W)) u_checker (
    .clk_i(clk), .rst_i(rst), .start_i(start), .base_i(base), .stride_i(stride),
    .len_i(len), .fmt_i(fmt), .key_i(key), .busy_i(busy), .done_i(done),
    .mem_req_i(mem_req), .mem_gnt_i(mem_gnt), .mem_addr_i(mem_addr),
    .out_data_i(out_data), .out_valid_i(out_valid), .out_ready_i(out_ready),
    .errors_o(chk_errors), .jobs_done_o(jobs_done)
  );

  // Same mixing rule the checker uses to rebuild the expected data.
  function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] addr,
                                           input logic [31:0] k);
    logic [31:0] h;
    h = (32'(addr) * 32'h9e3779b1) ^ k;
    h = h ^ (h >> 15);
    if (h[3:0] == 4'd0) return 32'h8000_0000;
    if (h[3:0] == 4'd1) return {16'hffff, 4'h0, h[15:4]};
    return h;
  endfunction

  // One clock step that drives the memory model and ready on the falling edge.
  task automatic tick();
    @(negedge clk);
    start      = 1'b0;
    mem_rvalid = pend;
    mem_rdata  = mem_word(pend_addr, key);
    pend       = 1'b0;
    if (mem_req && gnt_wait == 0) begin
      mem_gnt   = 1'b1;
      pend      = 1'b1;
      pend_addr = mem_addr;  // Stable while req waits.
      gnt_wait  = int'($urandom_range(max_gnt_delay, 0));
    end else begin
      mem_gnt = 1'b0;
      if (mem_req && gnt_wait != 0) gnt_wait--;
    end
    out_ready = int'($urandom_range(99, 0)) < ready_pct;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((busy || done) && cycles < IDLE_TIMEOUT) begin
      tick();
      cycles++;
    end
    if (busy || done) begin
      $display("DUT did not return to idle within %0d cycles", IDLE_TIMEOUT);
      bench_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_job(input int job, input int n, input src_fmt_e f);
    int cycles;
    wait_idle();
    if (!timed_out) begin
      base   = ADDR_W'($urandom);
      stride = ADDR_W'($urandom);
      len    = LEN_W'(n);
      fmt    = f;
      key    = $urandom;
      start  = 1'b1;
      tick();
      cycles = 0;
      while (!mem_req && cycles < REQ_TIMEOUT) begin
        tick();
        cycles++;
      end
      if (!mem_req) begin
        $display("Job %0d: no memory request within %0d cycles", job, REQ_TIMEOUT);
        bench_errors++;
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      if (busy) begin
        base  = ADDR_W'($urandom);  // A start while busy must be ignored.
        fmt   = (f == FMT_INT16) ? FMT_FP16 : FMT_INT16;
        start = 1'b1;
      end
      cycles = 0;
      while (!done && cycles < DONE_TIMEOUT) begin
        tick();
        cycles++;
      end
      if (!done) begin
        $display("Job %0d: done_o did not arrive within %0d cycles", job, DONE_TIMEOUT);
        bench_errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int       n;
    src_fmt_e f;
    void'($urandom(32'hc42822f0));
    start = 1'b0;
    base = '0;
    stride = '0;
    len = '0;
    fmt = FMT_FP16;
    key = '0;
    mem_gnt = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    out_ready = 1'b0;
    pend = 1'b0;
    pend_addr = '0;
    gnt_wait = 0;
    max_gnt_delay = 0;
    ready_pct = 100;
    bench_errors = 0;
    timed_out = 1'b0;
    rst = 1'b1;
    repeat (3) tick();
    rst = 1'b0;
    tick();
    if (mem_req !== 1'b0 || out_valid !== 1'b0 || busy !== 1'b0 || done !== 1'b0) begin
      $display("Mismatch reset_outputs: expected %b, actual %b", 4'b0000,
               {mem_req, out_valid, busy, done});
      bench_errors++;
    end
    for (int j = 0; j < NUM_JOBS && !timed_out; j++) begin
      max_gnt_delay = (j < 2) ? 0 : int'($urandom_range(3, 0));
      ready_pct     = (j < 2) ? 100 : 25 + 25 * int'($urandom_range(3, 0));
      n             = (j < 2) ? 1 : int'($urandom_range(40, 2));
      f             = (j % 2 == 1) ? FMT_INT16 : FMT_FP16;
      run_job(j, n, f);
    end
    if (!timed_out) wait_idle();
    if (!timed_out && jobs_done != NUM_JOBS) begin
      $display("Mismatch done_count: expected %0d, actual %0d", NUM_JOBS, jobs_done);
      bench_errors++;
    end
    $display("Errors: %0d from the checker, %0d from the bench", chk_errors, bench_errors);
    if (chk_errors == 0 && bench_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/streamin_checker.sv ====
// Expects one accepted start per job and the memory words given by the shared mixing rule.
`timescale 1ns/1ps

module streamin_checker #(
  parameter int FIFO_DEPTH = streamin_pkg::FIFO_DEPTH_DEF,
  parameter int ADDR_W     = streamin_pkg::ADDR_W
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            start_i,
  input  logic [ADDR_W-1:0]               base_i,
  input  logic [ADDR_W-1:0]               stride_i,
  input  logic [streamin_pkg::LEN_W-1:0]  len_i,
  input  streamin_pkg::src_fmt_e          fmt_i,
  input  logic [31:0]                     key_i,
  input  logic                            busy_i,
  input  logic                            done_i,
  input  logic                            mem_req_i,
  input  logic                            mem_gnt_i,
  input  logic [ADDR_W-1:0]               mem_addr_i,
  input  logic [streamin_pkg::DATA_W-1:0] out_data_i,
  input  logic                            out_valid_i,
  input  logic                            out_ready_i,
  output int                              errors_o,
  output int                              jobs_done_o
);
  import streamin_pkg::*;

  logic [DATA_W-1:0] exp_q [$];  // Expected output words in order.
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] stride_q;
  logic [31:0]       key_q;
  src_fmt_e          fmt_q;
  bit                job_active = 1'b0;
  int                len_q;
  int                grant_cnt = 0;
  int                out_cnt = 0;
  int                job_idx = 0;
  int                err_cnt = 0;
  int                done_cnt = 0;

  assign errors_o    = err_cnt;
  assign jobs_done_o = done_cnt;

  // Fixed mix of address and job key; some words hold 0, -1 and -32768 lanes.
  function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] addr,
                                           input logic [31:0] k);
    logic [31:0] h;
    h = (32'(addr) * 32'h9e3779b1) ^ k;
    h = h ^ (h >> 15);
    if (h[3:0] == 4'd0) return 32'h8000_0000;
    if (h[3:0] == 4'd1) return {16'hffff, 4'h0, h[15:4]};
    return h;
  endfunction

  // Reference FP16 of a signed lane, round to nearest, ties to even.
  function automatic logic [15:0] fp16_of_int(input logic [15:0] v);
    int   m;
    int   e;
    int   q;
    int   r;
    int   half;
    logic s;
    s = v[15];
    m = s ? 65536 - int'(v) : int'(v);
    if (m == 0) return 16'h0000;
    e = 0;
    while ((m >> (e + 1)) != 0) e++;
    if (e <= 10) begin
      q = m << (10 - e);  // Exact.
    end else begin
      q    = m >> (e - 10);
      r    = m - (q << (e - 10));
      half = 1 << (e - 11);
      if (r > half || (r == half && (q % 2) == 1)) q++;
      if (q == 2048) begin
        q = 1024;
        e++;
      end
    end
    return {s, 5'(e + 15), 10'(q)};
  endfunction

  task automatic note_error(input string msg);
    $display("Error in job %0d: %s", job_idx, msg);
    err_cnt++;
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Mismatch %s in job %0d: expected %h, actual %h", name, job_idx, exp, act);
    err_cnt++;
  endtask

  task automatic begin_job();
    if (exp_q.size() != 0) note_error("words of the previous job never came out");
    exp_q.delete();
    job_idx++;
    job_active = 1'b1;
    base_q     = base_i;
    stride_q   = stride_i;
    len_q      = int'(len_i);
    fmt_q      = fmt_i;
    key_q      = key_i;
    grant_cnt  = 0;
    out_cnt    = 0;
  endtask

  task automatic check_grant();
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] word;
    if (!job_active || grant_cnt >= len_q) begin
      note_error("memory request outside the length of a job");
    end else begin
      exp_addr = base_q + ADDR_W'(grant_cnt) * stride_q;  // Wraps at 2**ADDR_W.
      if (mem_addr_i !== exp_addr) mismatch("address", 32'(exp_addr), 32'(mem_addr_i));
      word = mem_word(exp_addr, key_q);
      if (fmt_q == FMT_INT16) exp_q.push_back({fp16_of_int(word[31:16]), fp16_of_int(word[15:0])});
      else exp_q.push_back(word);
      grant_cnt++;
    end
  endtask

  task automatic check_output();
    logic [DATA_W-1:0] exp;
    if (exp_q.size() == 0) begin
      note_error("output word with no matching memory read");
    end else begin
      exp = exp_q.pop_front();
      if (out_data_i !== exp) begin
        mismatch(fmt_q == FMT_INT16 ? "int16_cast" : "fp16_pass", exp, out_data_i);
      end
    end
    out_cnt++;
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      job_active = 1'b0;
      grant_cnt  = 0;
      out_cnt    = 0;
      exp_q.delete();
    end else begin
      if (busy_i && !job_active) note_error("busy_o is high with no job running");
      if (job_active && !busy_i && !done_i) note_error("busy_o dropped before done_o");
      if (done_i && !job_active) note_error("done_o pulsed with no job running");
      if (mem_req_i && mem_gnt_i) check_grant();
      if (out_valid_i && out_ready_i) check_output();
      if (grant_cnt - out_cnt > FIFO_DEPTH + 1) note_error("too many words granted but not output");
      if (done_i) done_cnt++;
      if (done_i && job_active) begin
        if (out_cnt != len_q) mismatch("length", 32'(len_q), 32'(out_cnt));
        job_active = 1'b0;
      end
      if (start_i && !busy_i && !done_i) begin_job();  // Only an idle DUT takes a start.
    end
  end

endmodule

// ==== source/streamin_top.sv ====
// fmt_i is sampled only with an accepted start_i; memory must answer one cycle after gnt.
`timescale 1ns/1ps

module streamin_top #(
  parameter int FIFO_DEPTH = streamin_pkg::FIFO_DEPTH_DEF,
  parameter int ADDR_W     = streamin_pkg::ADDR_W
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            start_i,
  input  logic [ADDR_W-1:0]               base_i,
  input  logic [ADDR_W-1:0]               stride_i,
  input  logic [streamin_pkg::LEN_W-1:0]  len_i,
  input  streamin_pkg::src_fmt_e          fmt_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            mem_req_o,
  output logic [ADDR_W-1:0]               mem_addr_o,
  input  logic                            mem_gnt_i,
  input  logic                            mem_rvalid_i,
  input  logic [streamin_pkg::DATA_W-1:0] mem_rdata_i,
  output logic [streamin_pkg::DATA_W-1:0] out_data_o,
  output logic                            out_valid_o,
  input  logic                            out_ready_i
);
  import streamin_pkg::*;

  localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

  logic [FREE_W-1:0] fifo_free;
  logic [DATA_W-1:0] fifo_data;
  logic              fifo_valid;
  logic              cast_ready;
  logic              out_fire;
  src_fmt_e          fmt_q;

  mem_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_bus ();

  assign mem_req_o       = mem_bus.req;
  assign mem_addr_o      = mem_bus.addr;
  assign mem_bus.gnt     = mem_gnt_i;
  assign mem_bus.r_valid = mem_rvalid_i;
  assign mem_bus.r_data  = mem_rdata_i;

  assign out_fire = out_valid_o && out_ready_i;

  // Format is held for the whole job, same condition the FSM uses for start.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fmt_q <= FMT_FP16;
    end else if (start_i && !busy_o && !done_o) begin
      fmt_q <= fmt_i;
    end
  end

  streamin_ctrl #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .ADDR_W     ( ADDR_W     )
  ) i_ctrl (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .start_i    ( start_i   ),
    .base_i     ( base_i    ),
    .stride_i   ( stride_i  ),
    .len_i      ( len_i     ),
    .free_i     ( fifo_free ),
    .out_fire_i ( out_fire  ),
    .mem        ( mem_bus   ),
    .busy_o     ( busy_o    ),
    .done_o     ( done_o    )
  );

  load_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_load_fifo (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .mem     ( mem_bus    ),
    .data_o  ( fifo_data  ),
    .valid_o ( fifo_valid ),
    .ready_i ( cast_ready ),
    .free_o  ( fifo_free  )
  );

  cast_in i_cast (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .fmt_i   ( fmt_q       ),
    .data_i  ( fifo_data   ),
    .valid_i ( fifo_valid  ),
    .ready_o ( cast_ready  ),
    .data_o  ( out_data_o  ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i )
  );

endmodule

// ==== source/cast_in.sv ====
// INT16 lanes become FP16 with round to nearest even; FP16 lanes pass through untouched.
`timescale 1ns/1ps

module cast_in (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  streamin_pkg::src_fmt_e          fmt_i,
  input  logic [streamin_pkg::DATA_W-1:0] data_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  output logic [streamin_pkg::DATA_W-1:0] data_o,
  output logic                            valid_o,
  input  logic                            ready_i
);
  import streamin_pkg::*;

  localparam int NUM_LANES = DATA_W / LANE_W;

  logic [DATA_W-1:0] conv;
  logic [DATA_W-1:0] data_q;
  logic              valid_q;

  // Signed 16-bit integer to IEEE half precision.
  function automatic logic [15:0] int16_to_fp16(input logic [15:0] val);
    logic [15:0] mag;
    logic [15:0] norm;
    logic [4:0]  lead;
    logic        round_up;
    logic [10:0] rnd;
    mag  = val[15] ? (~val + 16'd1) : val;  // -32768 gives 16'h8000.
    lead = '0;
    for (int i = 0; i < 16; i++) begin
      if (mag[i]) lead = 5'(i);  // Highest set bit wins.
    end
    norm     = mag << (4'd15 - lead[3:0]);  // Leading one now at bit 15.
    round_up = norm[4] && ((norm[3:0] != '0) || norm[5]);  // Guard, sticky, lsb.
    rnd      = {1'b0, norm[14:5]} + 11'(round_up);
    if (mag == '0) return 16'h0000;
    // A mantissa carry bumps the exponent and leaves the fraction at zero.
    return {val[15], 5'd15 + lead + 5'(rnd[10]), rnd[9:0]};
  endfunction

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (fmt_i == FMT_INT16) begin
        conv[l*LANE_W +: LANE_W] = int16_to_fp16(data_i[l*LANE_W +: LANE_W]);
      end else begin
        conv[l*LANE_W +: LANE_W] = data_i[l*LANE_W +: LANE_W];
      end
    end
  end

  // Single output stage, takes a new word when empty or being drained.
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) data_q <= conv;  // Holds while the sink stalls.
  end

endmodule

// ==== source/load_fifo.sv ====
// Has no overflow protection of its own; the requester must reserve a slot per read.
`timescale 1ns/1ps

module load_fifo #(
  parameter int  FIFO_DEPTH = streamin_pkg::FIFO_DEPTH_DEF,
  localparam int FREE_W     = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  mem_if.target                           mem,
  output logic [streamin_pkg::DATA_W-1:0] data_o,
  output logic                            valid_o,
  input  logic                            ready_i,
  output logic [FREE_W-1:0]               free_o
);
  import streamin_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic [DATA_W-1:0] buf_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [FREE_W-1:0] count_q;
  logic              push;
  logic              pop;

  // Pointer step that also works for depths that are not a power of two.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign push    = mem.r_valid;          // Every response is accepted.
  assign pop     = valid_o && ready_i;
  assign valid_o = count_q != '0;
  assign data_o  = buf_q[rd_ptr_q];      // Head word, stable until popped.
  assign free_o  = FREE_W'(FIFO_DEPTH) - count_q;

  always_ff @(posedge clk_i) begin
    if (push) buf_q[wr_ptr_q] <= mem.r_data;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The requester's slot reservation must keep responses out of a full FIFO.
  assert property (@(posedge clk_i) disable iff (rst_i)
    push |-> count_q < FREE_W'(FIFO_DEPTH))
    else $error("Response written into a full FIFO.");

endmodule

// ==== source/streamin_ctrl.sv ====
// len_i must be nonzero; start_i is ignored unless idle and only reset aborts a job.
`timescale 1ns/1ps

module streamin_ctrl #(
  parameter int   FIFO_DEPTH = streamin_pkg::FIFO_DEPTH_DEF,
  parameter int   ADDR_W     = streamin_pkg::ADDR_W,
  localparam int  FREE_W     = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           start_i,
  input  logic [ADDR_W-1:0]              base_i,
  input  logic [ADDR_W-1:0]              stride_i,
  input  logic [streamin_pkg::LEN_W-1:0] len_i,
  input  logic [FREE_W-1:0]              free_i,
  input  logic                           out_fire_i,
  mem_if.initiator                       mem,
  output logic                           busy_o,
  output logic                           done_o
);
  import streamin_pkg::*;

  ctrl_state_e       state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  issue_cnt_q;  // Words granted so far.
  logic [LEN_W-1:0]  out_cnt_q;    // Words accepted at the output.
  logic [FREE_W-1:0] outst_q;      // Granted, response not yet in the FIFO.
  logic              grant;
  logic              last_issue;
  logic              last_out;

  // A slot is reserved for every grant, so only request with spare room.
  assign mem.req  = (state_q == ST_RUN) && (outst_q < free_i);
  assign mem.addr = addr_q;

  assign grant      = mem.req && mem.gnt;
  assign last_issue = issue_cnt_q == len_q - 1'b1;
  assign last_out   = out_cnt_q == len_q - 1'b1;

  assign busy_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
  assign done_o = state_q == ST_DONE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      issue_cnt_q <= '0;
      out_cnt_q   <= '0;
      outst_q     <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q     <= ST_RUN;
            issue_cnt_q <= '0;
            out_cnt_q   <= '0;
          end
        end
        ST_RUN: begin
          if (grant && last_issue) state_q <= ST_DRAIN;  // Last read granted.
        end
        ST_DRAIN: begin
          if (out_fire_i && last_out) state_q <= ST_DONE;
        end
        default: state_q <= ST_IDLE;  // ST_DONE lasts one cycle.
      endcase

      if (grant) issue_cnt_q <= issue_cnt_q + 1'b1;
      if (out_fire_i && busy_o) out_cnt_q <= out_cnt_q + 1'b1;

      case ({grant, mem.r_valid})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;  // Both or neither cancel out.
      endcase
    end
  end

  // Job parameters and the running address.
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end else if (grant) begin
      addr_q <= addr_q + stride_q;  // Wraps at 2**ADDR_W.
    end
  end

  // A pending request keeps its address until the memory grants it.
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem.req && !mem.gnt |=> mem.req && $stable(mem.addr))
    else $error("Memory request withdrawn before its grant.");

  // Responses in flight plus FIFO words stay within the FIFO.
  assert property (@(posedge clk_i) disable iff (rst_i)
    outst_q <= free_i)
    else $error("More words reserved than FIFO slots.");

endmodule

// ==== source/mem_if.sv ====
// Read-only bus with one r_valid response exactly one cycle after each grant.
`timescale 1ns/1ps

interface mem_if #(
  parameter int ADDR_W = streamin_pkg::ADDR_W,
  parameter int DATA_W = streamin_pkg::DATA_W
) ();

  logic              req;      // Held with addr until gnt.
  logic              gnt;      // Request accepted this cycle.
  logic [ADDR_W-1:0] addr;     // Word address.
  logic              r_valid;  // Response strobe.
  logic [DATA_W-1:0] r_data;   // Response word.

  // The address generator side.
  modport initiator (
    output req,
    output addr,
    input  gnt,
    input  r_valid
  );

  // The response FIFO only sees the returning words.
  modport target (
    input r_valid,
    input r_data
  );

  // Edge toward the external memory.
  modport monitor (
    input  req,
    input  addr,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

// ==== source/streamin_pkg.sv ====
// Only FP16 and signed INT16 sources are supported, two 16-bit lanes per word.
package streamin_pkg;

  // Bus and job sizes.
  parameter int DATA_W         = 32;  // Two 16-bit lanes per word.
  parameter int LANE_W         = 16;  // One FP16 or INT16 element.
  parameter int ADDR_W         = 16;  // Word address, wraps modulo 2**ADDR_W.
  parameter int LEN_W          = 12;  // Words per job, zero is not a valid job.
  parameter int FIFO_DEPTH_DEF = 4;   // Response FIFO slots.

  // Source element format of a job.
  typedef enum logic {
    FMT_FP16  = 1'b0,  // Lanes already FP16.
    FMT_INT16 = 1'b1   // Signed INT16 lanes, converted on the way out.
  } src_fmt_e;

  // Job FSM of the control block.
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // Waiting for start.
    ST_RUN   = 2'd1,  // Issuing reads.
    ST_DRAIN = 2'd2,  // All reads granted, waiting for the last output.
    ST_DONE  = 2'd3   // One-cycle done pulse.
  } ctrl_state_e;

endpackage
